// ==== Bender.yml ====
package:
  name: dram_burst

sources:
  - include_dirs:
      - common
    files:
      - common/dram_burst_pkg.sv
      - design/dram_addr_gen.sv
      - design/refresh_timer.sv
      - dram_ctrl_fsm/dram_ctrl_fsm.sv
      - design/dram_burst_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/dram_burst_tb.sv

// ==== common/dram_burst_params.svh ====
// dram burst parameters
`ifndef DRAM_BURST_PARAMS_SVH
`define DRAM_BURST_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address geometry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DRAM_BANK_W 3   // 8 banks.
`define DRAM_ROW_W  7   // 128 rows.
`define DRAM_COL_W  3   // burst is 2**col_w reads.

// rows per burst request.
`define DRAM_ROWS_W 4

// cycles between refresh requests.
`define DRAM_REFRESH_INTERVAL 200

`endif

// ==== common/dram_burst_pkg.sv ====
// dram burst types
`default_nettype none
`include "dram_burst_params.svh"

package dram_burst_pkg;

    // controller states.
    typedef enum logic [2:0] {
        st_idle,
        st_activate,
        st_read,
        st_precharge,
        st_refresh
    } ctrl_state_e;

    // device command encoding.
    typedef enum logic [1:0] {
        op_activate  = 2'b00,
        op_read      = 2'b01,
        op_refresh   = 2'b10,
        op_precharge = 2'b11
    } dram_cmd_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host request, device command, working address.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`DRAM_BANK_W-1:0] bank;
        logic [`DRAM_ROW_W-1:0]  row;
        logic [`DRAM_COL_W-1:0]  col;   // start column.
        logic [`DRAM_ROWS_W-1:0] rows;  // 0 and 1 both mean one row.
    } dram_req_t;

    typedef struct packed {
        dram_cmd_e               op;
        logic [`DRAM_BANK_W-1:0] bank;
        logic [`DRAM_ROW_W-1:0]  row;
        logic [`DRAM_COL_W-1:0]  col;
    } dram_cmd_t;

    typedef struct packed {
        logic [`DRAM_BANK_W-1:0] bank;
        logic [`DRAM_ROW_W-1:0]  row;
        logic [`DRAM_COL_W-1:0]  col;
    } dram_addr_t;

endpackage

`default_nettype wire

// ==== design/dram_addr_gen.sv ====
// burst address generator
`timescale 1ns/1ps
`default_nettype none
`include "dram_burst_params.svh"

module dram_addr_gen
    import dram_burst_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_b,
    input  wire logic      load,
    input  wire dram_req_t req,
    input  wire logic      row_inc,
    input  wire logic      col_inc,
    output dram_addr_t     addr
);

    logic [`DRAM_COL_W-1:0] start_col;  // restored at each new row.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // start column buffer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            start_col <= '0;
        end else if (load) begin
            start_col <= req.col;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // working address.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            addr <= '0;
        end else if (load) begin
            addr.bank <= req.bank;
            addr.row  <= req.row;
            addr.col  <= req.col;
        end else if (row_inc) begin
            // row wraps mod 128 by width.
            addr.row <= addr.row + 1'b1;
            addr.col <= start_col;
        end else if (col_inc) begin
            addr.col <= addr.col + 1'b1;  // wraps within the burst.
        end
    end

endmodule

`default_nettype wire

// ==== design/dram_burst_top.sv ====
// dram burst controller top
`timescale 1ns/1ps
`default_nettype none

module dram_burst_top
    import dram_burst_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_b,
    input  wire logic      addr_val,
    input  wire dram_req_t req,
    input  wire logic      cmd_ack,
    output logic           busy,
    output logic           cmd_req,
    output dram_cmd_t      cmd
);

    logic       load;
    logic       row_inc;
    logic       col_inc;
    logic       refresh_pending;
    logic       refresh_done;
    dram_addr_t addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command sequencer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    dram_ctrl_fsm dram_ctrl_fsm_inst (
        .clk             (clk),
        .rst_b           (rst_b),
        .addr_val        (addr_val),
        .rows            (req.rows),
        .addr            (addr),
        .refresh_pending (refresh_pending),
        .cmd_ack         (cmd_ack),
        .cmd_req         (cmd_req),
        .cmd             (cmd),
        .busy            (busy),
        .load            (load),
        .row_inc         (row_inc),
        .col_inc         (col_inc),
        .refresh_done    (refresh_done)
    );

    dram_addr_gen dram_addr_gen_inst (
        .clk     (clk),
        .rst_b   (rst_b),
        .load    (load),
        .req     (req),
        .row_inc (row_inc),
        .col_inc (col_inc),
        .addr    (addr)
    );

    refresh_timer refresh_timer_inst (
        .clk             (clk),
        .rst_b           (rst_b),
        .refresh_done    (refresh_done),
        .refresh_pending (refresh_pending)
    );

endmodule

`default_nettype wire

// ==== design/refresh_timer.sv ====
// refresh interval timer
`timescale 1ns/1ps
`default_nettype none
`include "dram_burst_params.svh"

module refresh_timer (
    input  wire logic clk,
    input  wire logic rst_b,
    input  wire logic refresh_done,
    output logic      refresh_pending
);

    localparam int CNT_W = $clog2(`DRAM_REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] cnt;

    // counts while nothing is pending, then parks until the refresh is taken.
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cnt             <= '0;
            refresh_pending <= 1'b0;
        end else if (refresh_done) begin
            cnt             <= '0;
            refresh_pending <= 1'b0;
        end else if (!refresh_pending) begin
            if (cnt == CNT_W'(`DRAM_REFRESH_INTERVAL - 1)) begin
                refresh_pending <= 1'b1;  // sticky.
            end
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== dram_burst.f ====
+incdir+common
common/dram_burst_pkg.sv
design/dram_addr_gen.sv
design/refresh_timer.sv
dram_ctrl_fsm/dram_ctrl_fsm.sv
design/dram_burst_top.sv
test/dram_burst_tb.sv

// ==== dram_ctrl_fsm/dram_ctrl_fsm.sv ====
// dram command sequencer
`timescale 1ns/1ps
`default_nettype none
`include "dram_burst_params.svh"

module dram_ctrl_fsm
    import dram_burst_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst_b,
    input  wire logic                    addr_val,
    input  wire logic [`DRAM_ROWS_W-1:0] rows,
    input  wire dram_addr_t              addr,
    input  wire logic                    refresh_pending,
    input  wire logic                    cmd_ack,
    output logic                         cmd_req,
    output dram_cmd_t                    cmd,
    output logic                         busy,
    output logic                         load,
    output logic                         row_inc,
    output logic                         col_inc,
    output logic                         refresh_done
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    ctrl_state_e resume;        // where to go once the refresh is taken.
    ctrl_state_e resume_nxt;

    logic [`DRAM_COL_W-1:0]  read_cnt;
    logic [`DRAM_ROWS_W-1:0] rows_left;
    logic                    taken;
    logic                    last_row;

    // request is a level, held for as long as we are out of idle.
    assign busy     = (state != st_idle);
    assign cmd_req  = busy;
    assign taken    = cmd_req && cmd_ack;
    assign last_row = (rows_left <= 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state and strobes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nxt    = state;
        resume_nxt   = resume;
        load         = 1'b0;
        row_inc      = 1'b0;
        col_inc      = 1'b0;
        refresh_done = 1'b0;

        case (state)
            st_idle: begin
                load = addr_val;
                // all banks closed here, so a refresh may go first.
                if (refresh_pending) begin
                    state_nxt  = st_refresh;
                    resume_nxt = addr_val ? st_activate : st_idle;
                end else if (addr_val) begin
                    state_nxt = st_activate;
                end
            end

            st_activate: begin
                if (taken) begin
                    state_nxt = st_read;
                end
            end

            st_read: begin
                if (taken) begin
                    col_inc = 1'b1;
                    if (&read_cnt) begin  // eighth read.
                        state_nxt = st_precharge;
                    end
                end
            end

            st_precharge: begin
                if (taken) begin
                    row_inc = !last_row;
                    if (refresh_pending) begin
                        state_nxt  = st_refresh;
                        resume_nxt = last_row ? st_idle : st_activate;
                    end else begin
                        state_nxt = last_row ? st_idle : st_activate;
                    end
                end
            end

            st_refresh: begin
                if (taken) begin
                    refresh_done = 1'b1;
                    state_nxt    = resume;
                end
            end

            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state, read and row counters.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state     <= st_idle;
            resume    <= st_idle;
            read_cnt  <= '0;
            rows_left <= '0;
        end else begin
            state  <= state_nxt;
            resume <= resume_nxt;

            if (state == st_activate && taken) begin
                read_cnt <= '0;
            end else if (col_inc) begin
                read_cnt <= read_cnt + 1'b1;
            end

            if (load) begin
                rows_left <= rows;
            end else if (row_inc) begin
                rows_left <= rows_left - 1'b1;
            end
        end
    end

    // op follows the state, address comes straight from the generator.
    always_comb begin
        cmd.bank = addr.bank;
        cmd.row  = addr.row;
        cmd.col  = addr.col;
        case (state)
            st_read:      cmd.op = op_read;
            st_precharge: cmd.op = op_precharge;
            st_refresh:   cmd.op = op_refresh;
            default:      cmd.op = op_activate;
        endcase
    end

endmodule

`default_nettype wire

// ==== test/dram_burst_golden.txt ====
# one read burst per line, decimal: bank row col rows ack_delay
# ack_delay holds cmd_ack low per command and scales the idle gap after the burst
0 0 0 1 0
3 17 5 1 1
7 127 2 1 0
1 40 7 2 2
5 126 3 4 0
2 100 1 3 1
4 12 6 0 0
6 64 4 2 3
0 125 0 5 1
3 9 2 10 10
1 77 5 1 0
7 3 1 15 1
2 50 7 2 0
5 90 3 1 2
4 127 6 3 0
6 33 0 1 1
0 111 4 8 0
3 1 1 2 3
1 60 2 1 0
7 126 7 2 1
2 88 5 1 0
5 20 3 6 2

// ==== test/dram_burst_tb.sv ====
// dram burst testbench
`timescale 1ns/1ps
`default_nettype none
`include "dram_burst_params.svh"

module dram_burst_tb
    import dram_burst_pkg::*;
();

    localparam int BURST_LEN = 1 << `DRAM_COL_W;
    localparam int ROW_COUNT = 1 << `DRAM_ROW_W;
    localparam int GAP_SCALE = 24;  // idle cycles per unit of ack delay.

    logic      clk;
    logic      rst_b;
    logic      addr_val;
    dram_req_t req;
    logic      cmd_ack;
    logic      busy;
    logic      cmd_req;
    dram_cmd_t cmd;

    integer    seed = 32'he60239ba;
    int        ack_delay = 0;
    int        timeout_limit = 1000000;
    int        cycle_cnt = 0;
    int        last_refresh = 0;
    int        refresh_cnt = 0;
    int        idle_refresh_cnt = 0;
    logic      refresh_ok = 1'b1;
    logic      from_idle = 1'b1;
    logic      hold_valid = 1'b0;
    logic      was_busy = 1'b0;
    dram_cmd_t held_cmd;
    dram_cmd_e last_op = op_refresh;

    dram_cmd_t exp_q[$];   // expected non-refresh commands.
    int        line_bank[$];
    int        line_row[$];
    int        line_col[$];
    int        line_rows[$];
    int        line_delay[$];

    dram_burst_top dram_burst_top_inst (
        .clk      (clk),
        .rst_b    (rst_b),
        .addr_val (addr_val),
        .req      (req),
        .cmd_ack  (cmd_ack),
        .busy     (busy),
        .cmd_req  (cmd_req),
        .cmd      (cmd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_fail;
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string msg);
        if (actual !== expected) begin
            $display("error at time %0t: %s (got 0x%0h, expected 0x%0h)",
                     $time, msg, actual, expected);
            report_fail();
        end
    endtask

    // one row is activate, a full burst of reads, precharge.
    task automatic expand_burst(input int bank, input int row, input int col, input int rows);
        dram_cmd_t c;
        int        n;
        int        r_abs;
        int        c_abs;
        n = (rows == 0) ? 1 : rows;
        c.bank = bank[`DRAM_BANK_W-1:0];
        for (int r = 0; r < n; r++) begin
            r_abs = (row + r) % ROW_COUNT;
            c.row = r_abs[`DRAM_ROW_W-1:0];
            c.col = col[`DRAM_COL_W-1:0];
            c.op  = op_activate;
            exp_q.push_back(c);
            for (int k = 0; k < BURST_LEN; k++) begin
                c_abs = (col + k) % BURST_LEN;
                c.col = c_abs[`DRAM_COL_W-1:0];
                c.op  = op_read;
                exp_q.push_back(c);
            end
            c.col = col[`DRAM_COL_W-1:0];
            c.op  = op_precharge;
            exp_q.push_back(c);
        end
    endtask

    task automatic take_command(input dram_cmd_t c);
        dram_cmd_t exp;
        if (c.op == op_refresh) begin
            compare_value(refresh_ok, 1'b1, "refresh issued while a bank was open");
            compare_value((cycle_cnt - last_refresh) >= `DRAM_REFRESH_INTERVAL, 1'b1,
                          "refreshes closer than the refresh interval");
            last_refresh = cycle_cnt;
            refresh_cnt++;
            if (from_idle && exp_q.size() == 0) idle_refresh_cnt++;  // no burst requested.
            refresh_ok = 1'b0;
        end else begin
            if (exp_q.size() == 0) begin
                $display("a command was taken while none was expected");
                report_fail();
            end
            exp = exp_q.pop_front();
            compare_value(c.op, exp.op, "wrong command op");
            compare_value(c.bank, exp.bank, "wrong bank");
            compare_value(c.row, exp.row, "wrong row");
            if (c.op == op_read) compare_value(c.col, exp.col, "wrong read column");
            refresh_ok = (c.op == op_precharge);  // banks closed again.
        end
        from_idle = 1'b0;
        last_op   = c.op;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // device model and bus monitor.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : device
        int   wait_left;
        logic new_cmd;
        cmd_ack   = 1'b0;
        wait_left = 0;
        new_cmd   = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (!cmd_req) begin
                cmd_ack = 1'b0;
                new_cmd = 1'b1;
            end else begin
                if (new_cmd) begin
                    wait_left = ack_delay + ($random(seed) & 1);
                    new_cmd   = 1'b0;
                end
                if (wait_left == 0) begin
                    cmd_ack = 1'b1;
                    new_cmd = 1'b1;  // taken at the next edge.
                end else begin
                    cmd_ack   = 1'b0;
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    initial begin : monitor
        forever begin
            @(negedge clk);
            if (rst_b) begin
                cycle_cnt++;
                if (cycle_cnt > timeout_limit) begin
                    $display("timeout after %0d cycles, the controller stopped making progress",
                             cycle_cnt);
                    report_fail();
                end
                compare_value(cmd_req, busy, "cmd_req differs from busy");
                if (hold_valid) begin
                    compare_value(cmd_req, 1'b1, "cmd_req dropped before cmd_ack");
                    compare_value(cmd, held_cmd, "cmd changed under back-pressure");
                end
                if (!busy) begin
                    if (was_busy) begin
                        compare_value(last_op == op_precharge || last_op == op_refresh, 1'b1,
                                      "busy fell before a precharge or refresh");
                    end
                    refresh_ok = 1'b1;
                    from_idle  = 1'b1;
                end
                if (cmd_req && cmd_ack) begin
                    hold_valid = 1'b0;
                    take_command(cmd);
                end else begin
                    hold_valid = cmd_req;
                    held_cmd   = cmd;
                end
                was_busy = busy;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_idle;
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_burst(input int idx);
        int b;
        int r;
        int c;
        int n;
        b = line_bank[idx];
        r = line_row[idx];
        c = line_col[idx];
        n = line_rows[idx];
        wait_idle();
        expand_burst(b, r, c, n);
        ack_delay = line_delay[idx];
        req.bank  = b[`DRAM_BANK_W-1:0];
        req.row   = r[`DRAM_ROW_W-1:0];
        req.col   = c[`DRAM_COL_W-1:0];
        req.rows  = n[`DRAM_ROWS_W-1:0];
        addr_val  = 1'b1;
        @(posedge clk);
        #1;
        addr_val = 1'b0;
        compare_value(busy, 1'b1, "busy did not rise after addr_val");
        repeat (3) @(posedge clk);
        #1;
        if (busy) begin
            req      = ~req;  // a stray request the DUT must ignore.
            addr_val = 1'b1;
            @(posedge clk);
            #1;
            addr_val = 1'b0;
        end
        wait_idle();
        compare_value(exp_q.size(), 0, "burst ended with commands still expected");
        repeat (line_delay[idx] * GAP_SCALE) @(posedge clk);
        #1;
    endtask

    initial begin : host
        int                 fd;
        int                 n;
        int                 b;
        int                 r;
        int                 c;
        int                 rows;
        int                 d;
        int                 total_rows;
        int                 max_delay;
        int                 gap_total;
        logic [8*128-1:0]   line_buf;
        rst_b      = 1'b0;
        addr_val   = 1'b0;
        req        = '0;
        total_rows = 0;
        max_delay  = 0;
        gap_total  = 0;

        fd = $fopen("test/dram_burst_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden stimulus file");
            report_fail();
        end
        while ($fgets(line_buf, fd) != 0) begin
            n = $sscanf(line_buf, "%d %d %d %d %d", b, r, c, rows, d);
            if (n == 5) begin
                line_bank.push_back(b);
                line_row.push_back(r);
                line_col.push_back(c);
                line_rows.push_back(rows);
                line_delay.push_back(d);
                total_rows += (rows == 0) ? 1 : rows;
                gap_total  += d * GAP_SCALE;
                if (d > max_delay) max_delay = d;
            end
        end
        $fclose(fd);
        timeout_limit = total_rows * (BURST_LEN + 2) * (max_delay + 2) + gap_total
                        + line_bank.size() * 16 + 1000;

        repeat (5) @(posedge clk);
        #1;
        rst_b = 1'b1;
        compare_value(busy, 1'b0, "busy high after reset");
        compare_value(cmd_req, 1'b0, "cmd_req high after reset");

        for (int i = 0; i < line_bank.size(); i++) begin
            run_burst(i);
        end

        wait_idle();
        repeat (4) @(posedge clk);
        #1;
        compare_value(refresh_cnt != 0, 1'b1, "no refresh command was seen");
        compare_value(idle_refresh_cnt != 0, 1'b1, "no refresh was issued from idle");
        if (exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("commands were still expected at the end of the run");
            report_fail();
        end
    end

endmodule

`default_nettype wire
